// ==== xfcp_pkg.sv ====
// Widths, protocol codes and link types shared by the XFCP control core.
// Design modules import it in their module headers.
package xfcp_pkg;

    localparam int DATA_W         = 32;
    localparam int ADDR_W         = 8;
    localparam int NUM_UP         = 2;
    localparam int UP_W           = $clog2(NUM_UP);
    localparam int NUM_RAM        = 3;
    localparam int PORT_W         = 2;
    localparam int BYTES_PER_WORD = 4;

    // Request commands and their response codes
    localparam logic [7:0] CMD_READ   = 8'h10;
    localparam logic [7:0] CMD_WRITE  = 8'h12;
    localparam logic [7:0] RESP_READ  = 8'h11;
    localparam logic [7:0] RESP_WRITE = 8'h13;
    localparam logic [7:0] RESP_ERROR = 8'hff;

    // One byte on a stream link
    typedef struct packed {
        logic [7:0] data;
        logic       last;
    } xfcp_beat_t;

    typedef struct packed {
        logic [ADDR_W-1:0] adr;
        logic [DATA_W-1:0] dat;
        logic              we;
        logic              stb;
        logic              cyc;
    } wb_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] dat;
        logic              ack;
    } wb_rsp_t;

    // Bus word, byte 0 is the least significant
    typedef union packed {
        logic [DATA_W-1:0]              word;
        logic [BYTES_PER_WORD-1:0][7:0] bytes;
    } wb_word_u;

endpackage

// ==== xfcp_arb.sv ====
// Round-robin arbiter that merges the upstream request ports into one stream.
// The grant holds until the response last beat has gone back to the winner.
`timescale 1ns/1ns

module xfcp_arb
    import xfcp_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  xfcp_beat_t [NUM_UP-1:0] up_req_i,
    input  logic       [NUM_UP-1:0] up_req_valid_i,
    output logic       [NUM_UP-1:0] up_req_ready_o,
    output xfcp_beat_t [NUM_UP-1:0] up_rsp_o,
    output logic       [NUM_UP-1:0] up_rsp_valid_o,
    input  logic       [NUM_UP-1:0] up_rsp_ready_i,
    output xfcp_beat_t              dn_req_o,
    output logic                    dn_req_valid_o,
    input  logic                    dn_req_ready_i,
    input  xfcp_beat_t              dn_rsp_i,
    input  logic                    dn_rsp_valid_i,
    output logic                    dn_rsp_ready_o
);

    logic [UP_W-1:0] grant_q;
    logic [UP_W-1:0] rr_ptr_q;
    logic [UP_W-1:0] pick;
    logic [UP_W-1:0] sel;
    logic            pick_vld;
    logic            busy_q;
    logic            req_done_q;
    logic            fwd_en;
    logic            req_fire;
    logic            rsp_fire;

    // Nearest requesting port at or after the pointer
    always_comb begin
        int idx;
        pick     = rr_ptr_q;
        pick_vld = 1'b0;
        for (int i = NUM_UP - 1; i >= 0; i--) begin
            idx = (int'(rr_ptr_q) + i) % NUM_UP;
            if (up_req_valid_i[idx]) begin
                pick     = UP_W'(idx);
                pick_vld = 1'b1;
            end
        end
    end

    // First beat passes in the same cycle the grant is taken
    assign sel            = busy_q ? grant_q : pick;
    assign fwd_en         = busy_q ? !req_done_q : pick_vld;
    assign dn_req_o       = up_req_i[sel];
    assign dn_req_valid_o = fwd_en && up_req_valid_i[sel];
    assign req_fire       = dn_req_valid_o && dn_req_ready_i;

    assign dn_rsp_ready_o = busy_q && up_rsp_ready_i[grant_q];
    assign rsp_fire       = dn_rsp_valid_i && dn_rsp_ready_o;

    always_comb begin
        for (int i = 0; i < NUM_UP; i++) begin
            up_req_ready_o[i] = fwd_en && (sel == UP_W'(i)) && dn_req_ready_i;
            up_rsp_o[i]       = dn_rsp_i;
            up_rsp_valid_o[i] = busy_q && (grant_q == UP_W'(i)) && dn_rsp_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            busy_q     <= 1'b0;
            req_done_q <= 1'b0;
            grant_q    <= '0;
            rr_ptr_q   <= '0;
        end else begin
            if (req_fire) begin
                if (!busy_q) begin
                    busy_q   <= 1'b1;
                    grant_q  <= pick;
                    rr_ptr_q <= (int'(pick) == NUM_UP - 1) ? '0 : pick + 1'b1;
                end
                // Hold off the next packet until the response is back
                if (dn_req_o.last) begin
                    req_done_q <= 1'b1;
                end
            end
            if (rsp_fire && dn_rsp_i.last) begin
                busy_q     <= 1'b0;
                req_done_q <= 1'b0;
            end
        end
    end

endmodule

// ==== xfcp_switch.sv ====
// 1-to-N switch: strips the route byte from a request and steers it to one endpoint.
// Responses come back with the route byte in front; bad routes get an error reply.
`timescale 1ns/1ns

module xfcp_switch
    import xfcp_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n_i,
    input  xfcp_beat_t               up_req_i,
    input  logic                     up_req_valid_i,
    output logic                     up_req_ready_o,
    output xfcp_beat_t               up_rsp_o,
    output logic                     up_rsp_valid_o,
    input  logic                     up_rsp_ready_i,
    output xfcp_beat_t [NUM_RAM-1:0] dn_req_o,
    output logic       [NUM_RAM-1:0] dn_req_valid_o,
    input  logic       [NUM_RAM-1:0] dn_req_ready_i,
    input  xfcp_beat_t [NUM_RAM-1:0] dn_rsp_i,
    input  logic       [NUM_RAM-1:0] dn_rsp_valid_i,
    output logic       [NUM_RAM-1:0] dn_rsp_ready_o
);

    typedef enum logic [2:0] {
        S_ROUTE,
        S_FWD,
        S_WAIT,
        S_HDR,
        S_RSP,
        S_DRAIN,
        S_ERR_HDR,
        S_ERR_CODE
    } state_t;

    state_t            state_q;
    logic [7:0]        route_q;
    logic [PORT_W-1:0] port_q;
    logic              req_fire;
    logic              rsp_fire;
    logic              route_ok;

    assign req_fire = up_req_valid_i && up_req_ready_o;
    assign rsp_fire = up_rsp_valid_o && up_rsp_ready_i;
    assign route_ok = int'(up_req_i.data) < NUM_RAM;

    always_comb begin
        up_req_ready_o = 1'b0;
        up_rsp_o       = '0;
        up_rsp_valid_o = 1'b0;
        for (int k = 0; k < NUM_RAM; k++) begin
            dn_req_o[k]       = up_req_i;
            dn_req_valid_o[k] = (state_q == S_FWD) && (port_q == PORT_W'(k)) && up_req_valid_i;
            dn_rsp_ready_o[k] = (state_q == S_RSP) && (port_q == PORT_W'(k)) && up_rsp_ready_i;
        end
        case (state_q)
            S_ROUTE, S_DRAIN: up_req_ready_o = 1'b1;
            S_FWD:            up_req_ready_o = dn_req_ready_i[port_q];
            S_HDR, S_ERR_HDR: begin
                up_rsp_o       = '{data: route_q, last: 1'b0};
                up_rsp_valid_o = 1'b1;
            end
            S_ERR_CODE: begin
                up_rsp_o       = '{data: RESP_ERROR, last: 1'b1};
                up_rsp_valid_o = 1'b1;
            end
            S_RSP: begin
                up_rsp_o       = dn_rsp_i[port_q];
                up_rsp_valid_o = dn_rsp_valid_i[port_q];
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= S_ROUTE;
        end else begin
            case (state_q)
                S_ROUTE: begin
                    if (req_fire) begin
                        // A route byte alone carries no request for the endpoint
                        if (up_req_i.last) begin
                            state_q <= S_ERR_HDR;
                        end else begin
                            state_q <= route_ok ? S_FWD : S_DRAIN;
                        end
                    end
                end
                S_FWD: if (req_fire && up_req_i.last) state_q <= S_WAIT;
                S_WAIT: if (dn_rsp_valid_i[port_q]) state_q <= S_HDR;
                S_HDR: if (rsp_fire) state_q <= S_RSP;
                S_RSP: if (rsp_fire && up_rsp_o.last) state_q <= S_ROUTE;
                S_DRAIN: if (req_fire && up_req_i.last) state_q <= S_ERR_HDR;
                S_ERR_HDR: if (rsp_fire) state_q <= S_ERR_CODE;
                S_ERR_CODE: if (rsp_fire) state_q <= S_ROUTE;
                default: state_q <= S_ROUTE;
            endcase
        end
    end

    // Route byte kept for the response header
    always_ff @(posedge clk) begin
        if (state_q == S_ROUTE && req_fire) begin
            route_q <= up_req_i.data;
            port_q  <= up_req_i.data[PORT_W-1:0];
        end
    end

endmodule

// ==== xfcp_mod_wb.sv ====
// Endpoint bridge: turns read and write request packets into Wishbone cycles
// and streams back the response header and any read data.
`timescale 1ns/1ns

module xfcp_mod_wb
    import xfcp_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n_i,
    input  xfcp_beat_t req_i,
    input  logic       req_valid_i,
    output logic       req_ready_o,
    output xfcp_beat_t rsp_o,
    output logic       rsp_valid_o,
    input  logic       rsp_ready_i,
    output wb_req_t    wb_o,
    input  wb_rsp_t    wb_i
);

    typedef enum logic [3:0] {
        S_CMD,
        S_ADDR,
        S_CNT,
        S_WDATA,
        S_WWB,
        S_DRAIN,
        S_HDR,
        S_RWB,
        S_RDATA
    } state_t;

    state_t            state_q;
    logic [1:0]        idx_q;
    logic [7:0]        cmd_q;
    logic [7:0]        addr_q;
    logic [7:0]        cnt_q;
    logic [7:0]        left_q;
    logic [ADDR_W-1:0] wadr_q;
    wb_word_u          word_q;
    logic [7:0]        code;
    logic              req_fire;
    logic              rsp_fire;
    logic              wb_act;
    logic              last_byte;
    logic              last_word;
    logic              has_rdata;

    assign req_ready_o = state_q inside {S_CMD, S_ADDR, S_CNT, S_WDATA, S_DRAIN};
    assign req_fire    = req_valid_i && req_ready_o;
    assign rsp_valid_o = (state_q == S_HDR) || (state_q == S_RDATA);
    assign rsp_fire    = rsp_valid_o && rsp_ready_i;
    assign last_byte   = idx_q == 2'(BYTES_PER_WORD - 1);
    assign last_word   = left_q == 8'd1;
    assign has_rdata   = (cmd_q == CMD_READ) && (cnt_q != 8'd0);

    // One word per cycle pair, strobe held until ack
    assign wb_act = (state_q == S_WWB) || (state_q == S_RWB);
    assign wb_o   = '{adr: wadr_q, dat: word_q.word, we: state_q == S_WWB,
                      stb: wb_act, cyc: wb_act};

    always_comb begin
        if (cmd_q == CMD_READ) begin
            code = RESP_READ;
        end else if (cmd_q == CMD_WRITE) begin
            code = RESP_WRITE;
        end else begin
            code = RESP_ERROR;
        end
    end

    always_comb begin
        rsp_o = '0;
        if (state_q == S_RDATA) begin
            rsp_o.data = word_q.bytes[idx_q];
            rsp_o.last = last_byte && last_word;
        end else begin
            case (idx_q)
                2'd0:    rsp_o.data = code;
                2'd1:    rsp_o.data = addr_q;
                default: rsp_o.data = cnt_q;
            endcase
            rsp_o.last = (idx_q == 2'd2) && !has_rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= S_CMD;
            idx_q   <= '0;
        end else begin
            case (state_q)
                S_CMD: if (req_fire) state_q <= S_ADDR;
                S_ADDR: if (req_fire) state_q <= S_CNT;
                S_CNT: begin
                    if (req_fire) begin
                        idx_q <= '0;
                        if (cmd_q == CMD_WRITE && req_i.data != 8'd0) begin
                            state_q <= S_WDATA;
                        end else if (req_i.last) begin
                            state_q <= S_HDR;
                        end else begin
                            // Unknown command with payload, throw it away
                            state_q <= S_DRAIN;
                        end
                    end
                end
                S_WDATA: begin
                    if (req_fire) begin
                        idx_q <= idx_q + 1'b1;
                        if (last_byte) state_q <= S_WWB;
                    end
                end
                S_WWB: if (wb_i.ack) state_q <= last_word ? S_HDR : S_WDATA;
                S_DRAIN: if (req_fire && req_i.last) state_q <= S_HDR;
                S_HDR: begin
                    if (rsp_fire) begin
                        if (idx_q == 2'd2) begin
                            idx_q   <= '0;
                            state_q <= has_rdata ? S_RWB : S_CMD;
                        end else begin
                            idx_q <= idx_q + 1'b1;
                        end
                    end
                end
                S_RWB: if (wb_i.ack) state_q <= S_RDATA;
                S_RDATA: begin
                    if (rsp_fire) begin
                        idx_q <= idx_q + 1'b1;
                        if (last_byte) state_q <= last_word ? S_CMD : S_RWB;
                    end
                end
                default: state_q <= S_CMD;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire) begin
            case (state_q)
                S_CMD: cmd_q <= req_i.data;
                S_ADDR: begin
                    addr_q <= req_i.data;
                    wadr_q <= req_i.data[ADDR_W-1:0];
                end
                S_CNT: begin
                    cnt_q  <= req_i.data;
                    left_q <= req_i.data;
                end
                // Little-endian word assembly
                S_WDATA: word_q.bytes[idx_q] <= req_i.data;
                default: ;
            endcase
        end
        if (state_q == S_RWB && wb_i.ack) begin
            word_q.word <= wb_i.dat;
        end
        // Step to the next word, address wraps at 8 bits
        if ((state_q == S_WWB && wb_i.ack) || (state_q == S_RDATA && rsp_fire && last_byte)) begin
            wadr_q <= wadr_q + 1'b1;
            left_q <= left_q - 1'b1;
        end
    end

endmodule

// ==== wb_ram.sv ====
// Wishbone RAM, 256 words by 32 bits, acked one cycle after the strobe.
`timescale 1ns/1ns

module wb_ram
    import xfcp_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n_i,
    input  wb_req_t wb_i,
    output wb_rsp_t wb_o
);

    logic [DATA_W-1:0] mem [2**ADDR_W];
    logic [DATA_W-1:0] rd_q;
    logic              ack_q;
    logic              access;

    // New access only while no ack is out
    assign access = wb_i.cyc && wb_i.stb && !ack_q;
    assign wb_o   = '{dat: rd_q, ack: ack_q};

    always_ff @(posedge clk) begin
        if (access) begin
            if (wb_i.we) begin
                mem[wb_i.adr] <= wb_i.dat;
            end
            rd_q <= mem[wb_i.adr];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

endmodule

// ==== xfcp_core.sv ====
// XFCP control core: two upstream ports, an arbiter, a route switch and
// three Wishbone RAM endpoints. The testbench drives the upstream ports.
`timescale 1ns/1ns

module xfcp_core
    import xfcp_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  xfcp_beat_t [NUM_UP-1:0] up_req_i,
    input  logic       [NUM_UP-1:0] up_req_valid_i,
    output logic       [NUM_UP-1:0] up_req_ready_o,
    output xfcp_beat_t [NUM_UP-1:0] up_rsp_o,
    output logic       [NUM_UP-1:0] up_rsp_valid_o,
    input  logic       [NUM_UP-1:0] up_rsp_ready_i
);

    // Arbiter to switch
    xfcp_beat_t sw_req;
    logic       sw_req_valid;
    logic       sw_req_ready;
    xfcp_beat_t sw_rsp;
    logic       sw_rsp_valid;
    logic       sw_rsp_ready;

    // Switch to endpoints
    xfcp_beat_t [NUM_RAM-1:0] ep_req;
    logic       [NUM_RAM-1:0] ep_req_valid;
    logic       [NUM_RAM-1:0] ep_req_ready;
    xfcp_beat_t [NUM_RAM-1:0] ep_rsp;
    logic       [NUM_RAM-1:0] ep_rsp_valid;
    logic       [NUM_RAM-1:0] ep_rsp_ready;

    wb_req_t [NUM_RAM-1:0] wb_req;
    wb_rsp_t [NUM_RAM-1:0] wb_rsp;

    xfcp_arb arb_inst (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .up_req_i       (up_req_i),
        .up_req_valid_i (up_req_valid_i),
        .up_req_ready_o (up_req_ready_o),
        .up_rsp_o       (up_rsp_o),
        .up_rsp_valid_o (up_rsp_valid_o),
        .up_rsp_ready_i (up_rsp_ready_i),
        .dn_req_o       (sw_req),
        .dn_req_valid_o (sw_req_valid),
        .dn_req_ready_i (sw_req_ready),
        .dn_rsp_i       (sw_rsp),
        .dn_rsp_valid_i (sw_rsp_valid),
        .dn_rsp_ready_o (sw_rsp_ready)
    );

    xfcp_switch switch_inst (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .up_req_i       (sw_req),
        .up_req_valid_i (sw_req_valid),
        .up_req_ready_o (sw_req_ready),
        .up_rsp_o       (sw_rsp),
        .up_rsp_valid_o (sw_rsp_valid),
        .up_rsp_ready_i (sw_rsp_ready),
        .dn_req_o       (ep_req),
        .dn_req_valid_o (ep_req_valid),
        .dn_req_ready_i (ep_req_ready),
        .dn_rsp_i       (ep_rsp),
        .dn_rsp_valid_i (ep_rsp_valid),
        .dn_rsp_ready_o (ep_rsp_ready)
    );

    // One bridge and RAM per switch port
    for (genvar g = 0; g < NUM_RAM; g++) begin : g_ep
        xfcp_mod_wb bridge_inst (
            .clk         (clk),
            .rst_n_i     (rst_n_i),
            .req_i       (ep_req[g]),
            .req_valid_i (ep_req_valid[g]),
            .req_ready_o (ep_req_ready[g]),
            .rsp_o       (ep_rsp[g]),
            .rsp_valid_o (ep_rsp_valid[g]),
            .rsp_ready_i (ep_rsp_ready[g]),
            .wb_o        (wb_req[g]),
            .wb_i        (wb_rsp[g])
        );

        wb_ram ram_inst (
            .clk     (clk),
            .rst_n_i (rst_n_i),
            .wb_i    (wb_req[g]),
            .wb_o    (wb_rsp[g])
        );
    end

endmodule

// ==== tb_xfcp_tasks.svh ====
// Testbench helpers for the XFCP core with the LFSR, the value check, stream send and
// receive, packet builders and the shadow RAM model. Included inside the testbench module.

typedef logic [7:0]  byte_q_t[$];
typedef logic [31:0] word_q_t[$];

logic [31:0] lfsr_q = 32'h104d_82a2;
int          check_count = 0;
int          error_count = 0;

// Reference copy of every endpoint RAM
logic [DATA_W-1:0] shadow [NUM_RAM][2**ADDR_W];

// Fibonacci LFSR with taps 32 22 2 1
function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    return fb;
endfunction

function automatic logic [31:0] rand_word();
    logic [31:0] w;
    w = '0;
    for (int i = 0; i < 32; i++) begin
        w = {w[30:0], lfsr_bit()};
    end
    return w;
endfunction

task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                     input string what);
    check_count++;
    if (actual !== expected) begin
        error_count++;
        $display("[ERROR] %0t ns: %s, got %0h, expected %0h", $time, what, actual, expected);
    end
endtask

task automatic compare_packets(input byte_q_t got, input byte_q_t exp, input string what);
    check(32'(got.size()), 32'(exp.size()), {what, " length"});
    for (int i = 0; i < got.size() && i < exp.size(); i++) begin
        check(32'(got[i]), 32'(exp[i]), $sformatf("%s byte %0d", what, i));
    end
endtask

// Header followed by each word in little-endian order
function automatic byte_q_t make_request(input logic [7:0] route, input logic [7:0] cmd,
                                         input logic [7:0] addr, input logic [7:0] cnt,
                                         input word_q_t words);
    byte_q_t q;
    q.push_back(route);
    q.push_back(cmd);
    q.push_back(addr);
    q.push_back(cnt);
    foreach (words[w]) begin
        for (int b = 0; b < BYTES_PER_WORD; b++) begin
            q.push_back(words[w][8*b +: 8]);
        end
    end
    return q;
endfunction

// Read response predicted from the shadow RAM
function automatic byte_q_t expect_read(input logic [PORT_W-1:0] route,
                                        input logic [7:0] addr, input logic [7:0] cnt);
    byte_q_t     q;
    word_q_t     data;
    logic [7:0]  a;
    a = addr;
    for (int w = 0; w < int'(cnt); w++) begin
        data.push_back(shadow[route][a]);
        a = a + 8'd1;
    end
    q = make_request(8'(route), RESP_READ, addr, cnt, data);
    return q;
endfunction

task automatic send_packet(input logic [UP_W-1:0] port, input byte_q_t bytes);
    int i;
    i = 0;
    while (i < bytes.size()) begin
        @(negedge clk);
        up_req[port].data  = bytes[i];
        up_req[port].last  = (i == bytes.size() - 1);
        up_req_valid[port] = 1'b1;
        #(CLK_PERIOD / 4);
        if (up_req_ready[port]) begin
            i++;
        end
    end
    @(negedge clk);
    up_req_valid[port] = 1'b0;
endtask

// Ready follows LFSR bits when stall is set
task automatic recv_packet(input logic [UP_W-1:0] port, input logic stall,
                           output byte_q_t bytes);
    logic done;
    done = 1'b0;
    bytes.delete();
    while (!done) begin
        @(negedge clk);
        up_rsp_ready[port] = stall ? lfsr_bit() : 1'b1;
        #(CLK_PERIOD / 4);
        // Only one transaction is in flight, so no other port may see a response
        check(32'(up_rsp_valid & ~(NUM_UP'(1) << port)), 32'd0,
              $sformatf("response valid on a port other than %0d", port));
        if (up_rsp_valid[port] && up_rsp_ready[port]) begin
            bytes.push_back(up_rsp[port].data);
            done = up_rsp[port].last;
        end
    end
    @(negedge clk);
    up_rsp_ready[port] = 1'b0;
endtask

task automatic write_words(input logic [UP_W-1:0] port, input logic [PORT_W-1:0] route,
                           input logic [7:0] addr, input word_q_t words);
    byte_q_t    req;
    byte_q_t    rsp;
    byte_q_t    exp;
    word_q_t    none;
    logic [7:0] a;
    req = make_request(8'(route), CMD_WRITE, addr, 8'(words.size()), words);
    send_packet(port, req);
    recv_packet(port, 1'b0, rsp);
    exp = make_request(8'(route), RESP_WRITE, addr, 8'(words.size()), none);
    compare_packets(rsp, exp, $sformatf("write route %0d addr %0h", route, addr));
    a = addr;
    foreach (words[w]) begin
        shadow[route][a] = words[w];
        a = a + 8'd1;
    end
endtask

task automatic read_words(input logic [UP_W-1:0] port, input logic [PORT_W-1:0] route,
                          input logic [7:0] addr, input logic [7:0] cnt, input logic stall);
    byte_q_t req;
    byte_q_t rsp;
    word_q_t none;
    req = make_request(8'(route), CMD_READ, addr, cnt, none);
    send_packet(port, req);
    recv_packet(port, stall, rsp);
    compare_packets(rsp, expect_read(route, addr, cnt),
                    $sformatf("read port %0d route %0d addr %0h", port, route, addr));
endtask

// ==== tb_xfcp_core.sv ====
// Testbench for the XFCP core. Runs directed tests over both upstream ports
// and checks every response against a shadow model of the three RAMs.
`timescale 1ns/1ns

module tb_xfcp_core
    import xfcp_pkg::*;
();

    localparam int CLK_PERIOD  = 20;
    localparam int NUM_TESTS   = 5;
    localparam int TEST_BUDGET = 2000;

    logic                    clk;
    logic                    rst_n;
    xfcp_beat_t [NUM_UP-1:0] up_req;
    logic       [NUM_UP-1:0] up_req_valid;
    logic       [NUM_UP-1:0] up_req_ready;
    xfcp_beat_t [NUM_UP-1:0] up_rsp;
    logic       [NUM_UP-1:0] up_rsp_valid;
    logic       [NUM_UP-1:0] up_rsp_ready;

    `include "tb_xfcp_tasks.svh"

    xfcp_core UUT (
        .clk            (clk),
        .rst_n_i        (rst_n),
        .up_req_i       (up_req),
        .up_req_valid_i (up_req_valid),
        .up_req_ready_o (up_req_ready),
        .up_rsp_o       (up_rsp),
        .up_rsp_valid_o (up_rsp_valid),
        .up_rsp_ready_i (up_rsp_ready)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Watchdog
    initial begin
        #(NUM_TESTS * TEST_BUDGET * CLK_PERIOD);
        $display("Timeout: tests did not finish within %0d cycles", NUM_TESTS * TEST_BUDGET);
        $display("Errors found");
        $finish;
    end

    task automatic write_then_read();
        word_q_t words;
        for (int r = 0; r < NUM_RAM; r++) begin
            words.delete();
            for (int w = 0; w < 4 + r; w++) begin
                words.push_back(rand_word());
            end
            write_words(UP_W'(r), PORT_W'(r), 8'h20 + 8'(16 * r), words);
            read_words(UP_W'(r), PORT_W'(r), 8'h20 + 8'(16 * r), 8'(4 + r), 1'b0);
        end
    endtask

    task automatic wrap_and_zero_count();
        word_q_t words;
        word_q_t none;
        for (int w = 0; w < 4; w++) begin
            words.push_back(rand_word());
        end
        write_words(1'b0, 2'd1, 8'd254, words);
        read_words(1'b0, 2'd1, 8'd254, 8'd4, 1'b0);
        read_words(1'b1, 2'd1, 8'd0, 8'd2, 1'b0);
        // Header-only response with last on the count byte
        read_words(1'b0, 2'd1, 8'd7, 8'd0, 1'b0);
        write_words(1'b1, 2'd1, 8'd9, none);
    endtask

    task automatic error_responses();
        word_q_t none;
        word_q_t junk;
        byte_q_t rsp;
        byte_q_t exp;
        send_packet(1'b0, make_request(8'd3, CMD_READ, 8'h00, 8'd1, none));
        recv_packet(1'b0, 1'b0, rsp);
        exp.push_back(8'd3);
        exp.push_back(RESP_ERROR);
        compare_packets(rsp, exp, "bad route");
        junk.push_back(rand_word());
        junk.push_back(rand_word());
        send_packet(1'b1, make_request(8'd0, 8'h55, 8'h20, 8'd2, junk));
        recv_packet(1'b1, 1'b0, rsp);
        compare_packets(rsp, make_request(8'd0, RESP_ERROR, 8'h20, 8'd2, none), "bad command");
        // RAM must still hold the earlier words
        read_words(1'b0, 2'd0, 8'h20, 8'd4, 1'b0);
    endtask

    task automatic two_senders();
        fork
            read_words(1'b0, 2'd0, 8'h20, 8'd2, 1'b0);
            read_words(1'b1, 2'd2, 8'h40, 8'd3, 1'b0);
        join
    endtask

    task automatic backpressure_reads();
        word_q_t words;
        for (int w = 0; w < 24; w++) begin
            words.push_back(rand_word());
        end
        write_words(1'b0, 2'd2, 8'h80, words);
        read_words(1'b0, 2'd2, 8'h80, 8'd24, 1'b1);
        read_words(1'b1, 2'd0, 8'h20, 8'd4, 1'b1);
        read_words(1'b1, 2'd1, 8'hfe, 8'd4, 1'b1);
    endtask

    initial begin
        rst_n        = 1'b0;
        up_req       = '0;
        up_req_valid = '0;
        up_rsp_ready = '0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        check(32'(up_rsp_valid), 32'd0, "response valid after reset");
        write_then_read();
        wrap_and_zero_count();
        error_responses();
        two_senders();
        backpressure_reads();
        repeat (4) @(negedge clk);
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+.
xfcp_pkg.sv
xfcp_arb.sv
xfcp_switch.sv
xfcp_mod_wb.sv
wb_ram.sv
xfcp_core.sv
tb_xfcp_core.sv

// ==== run.sh ====
#!/bin/sh
# Builds the XFCP core testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f compile.f --top-module tb_xfcp_core > build.log 2>&1 \
    && ./obj_dir/Vtb_xfcp_core > sim.log 2>&1 \
    || { echo "Build or simulation run failed, see build.log and sim.log"; exit 1; }
grep -q "Errors found" sim.log \
    && { echo "Simulation FAILED"; exit 1; } \
    || { echo "Simulation PASSED"; exit 0; }
